// File: hdl/core_pkg.sv
package core_pkg;

  // datapath and register-id widths
  localparam int CPU_WIDTH = 32;
  localparam int REG_ADDRW = 5;

  // data memory word address, 64 words
  localparam int DMEM_AW   = 6;

  typedef logic [CPU_WIDTH-1:0] word_t;
  typedef logic [REG_ADDRW-1:0] reg_id_t;

  // reduced instruction classes, already decoded
  typedef enum logic [2:0] {
    OP_NOP  = 3'd0,  // no effect, also used as bubble
    OP_ADD  = 3'd1,  // rd = rs1 + rs2
    OP_ADDI = 3'd2,  // rd = rs1 + imm
    OP_LW   = 3'd3,  // rd = mem[(rs1 + imm) >> 2]
    OP_SW   = 3'd4   // mem[(rs1 + imm) >> 2] = rs2
  } op_e;

endpackage

// File: hdl/regfile.sv
module regfile (
  input                      i_clk,
  input                      i_rst_n,
  // write port, driven from wb stage
  input                      i_wen,
  input  core_pkg::reg_id_t  i_waddr,
  input  core_pkg::word_t    i_wdata,
  // read ports for the instruction in id
  input  core_pkg::reg_id_t  i_raddr1,
  input  core_pkg::reg_id_t  i_raddr2,
  output core_pkg::word_t    o_rdata1,
  output core_pkg::word_t    o_rdata2,
  output logic               o_a0zero
);

  localparam int NUM_REGS = 1 << core_pkg::REG_ADDRW;

  core_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen) begin
      regs[i_waddr] <= i_wdata; // x0 protection lives upstream in idex_reg
    end
  end

  // asynchronous reads
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  assign o_a0zero = (regs[10] == '0); // x10 is a0

  // write enables are formed once in idex_reg from rd != 0,
  // so nothing along ex/ls/wb may turn a rd=0 op into a write
  a_no_x0_write : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_wen |-> (i_waddr != '0)
  );

endmodule

// File: hdl/bypass.sv
module bypass (
  input                      i_clk,
  input                      i_rst_n,
  // instruction in id
  input  core_pkg::reg_id_t  i_idu_rs1id,
  input  core_pkg::reg_id_t  i_idu_rs2id,
  input  core_pkg::op_e      i_idu_op,
  // ex stage
  input                      i_exu_lden,
  input                      i_exu_rdwen,
  input  core_pkg::reg_id_t  i_exu_rdid,
  input  core_pkg::word_t    i_exu_exres,
  // ls stage
  input                      i_lsu_lden,
  input                      i_lsu_rdwen,
  input  core_pkg::reg_id_t  i_lsu_rdid,
  input  core_pkg::word_t    i_lsu_exres,
  input  core_pkg::word_t    i_lsu_lsres,
  // wb stage
  input                      i_wbu_rdwen,
  input  core_pkg::reg_id_t  i_wbu_rdid,
  input  core_pkg::word_t    i_wbu_rd,
  // late store-data path
  input  core_pkg::word_t    i_exu_rs2,     // store data held in id/ex
  input                      i_exu_ldstbp,  // ldstbp one cycle later
  // outputs
  output core_pkg::word_t    o_idu_rs1,
  output core_pkg::word_t    o_idu_rs2,
  output logic               o_pc_wen,
  output logic               o_idex_bubble,
  output logic               o_idu_ldstbp,
  output core_pkg::word_t    o_exu_rs2,
  output logic               o_a0zero
);

  core_pkg::word_t rf_rs1;
  core_pkg::word_t rf_rs2;
  core_pkg::word_t ls_val;
  logic            rs1_used;
  logic            rs2_used;
  logic            exu_ld;
  logic            rs1_ld_hit;
  logic            rs2_ld_hit;

  regfile u_regfile (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_wen    (i_wbu_rdwen),
    .i_waddr  (i_wbu_rdid),
    .i_wdata  (i_wbu_rd),
    .i_raddr1 (i_idu_rs1id),
    .i_raddr2 (i_idu_rs2id),
    .o_rdata1 (rf_rs1),
    .o_rdata2 (rf_rs2),
    .o_a0zero (o_a0zero)
  );

  // value a ls-stage instruction will write
  assign ls_val = i_lsu_lden ? i_lsu_lsres : i_lsu_exres;

  // priority ex > ls > wb > regfile, a load in ex has no data yet
  function automatic core_pkg::word_t fwd_sel(input core_pkg::reg_id_t rid,
                                              input core_pkg::word_t  rf_val);
    core_pkg::word_t val;
    if (!i_exu_lden && i_exu_rdwen && (i_exu_rdid == rid)) begin
      val = i_exu_exres;
    end else if (i_lsu_rdwen && (i_lsu_rdid == rid)) begin
      val = ls_val;
    end else if (i_wbu_rdwen && (i_wbu_rdid == rid)) begin
      val = i_wbu_rd;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  always_comb begin
    o_idu_rs1 = fwd_sel(i_idu_rs1id, rf_rs1);
    o_idu_rs2 = fwd_sel(i_idu_rs2id, rf_rs2);
  end

  // only real source reads count as hazards
  assign rs1_used = (i_idu_op != core_pkg::OP_NOP);
  assign rs2_used = (i_idu_op == core_pkg::OP_ADD) || (i_idu_op == core_pkg::OP_SW);

  assign exu_ld     = i_exu_lden && i_exu_rdwen;
  assign rs1_ld_hit = exu_ld && rs1_used && (i_exu_rdid == i_idu_rs1id);
  assign rs2_ld_hit = exu_ld && rs2_used && (i_exu_rdid == i_idu_rs2id);

  // load then store of the loaded reg: no stall when store data is the only use
  assign o_idu_ldstbp  = rs2_ld_hit && (i_idu_op == core_pkg::OP_SW) && !rs1_ld_hit;
  assign o_idex_bubble = (rs1_ld_hit || rs2_ld_hit) && !o_idu_ldstbp;
  assign o_pc_wen      = !o_idex_bubble;

  // load is in ls by now, so its data replaces the stale store operand
  assign o_exu_rs2 = i_exu_ldstbp ? i_lsu_lsres : i_exu_rs2;

  // late store data is only meaningful while the load sits in ls
  a_ldstbp_has_load : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_exu_ldstbp |-> i_lsu_lden
  );

endmodule

// File: hdl/idex_reg.sv
module idex_reg (
  input                      i_clk,
  input                      i_rst_n,
  input                      i_valid,
  input                      i_bubble,
  input  core_pkg::op_e      i_op,
  input  core_pkg::reg_id_t  i_rdid,
  input  core_pkg::word_t    i_rs1,
  input  core_pkg::word_t    i_rs2,
  input  core_pkg::word_t    i_imm,
  input                      i_ldstbp,
  output core_pkg::op_e      o_op,
  output core_pkg::reg_id_t  o_rdid,
  output logic               o_rdwen,
  output logic               o_lden,
  output core_pkg::word_t    o_rs1,
  output core_pkg::word_t    o_rs2,
  output core_pkg::word_t    o_imm,
  output logic               o_ldstbp
);

  logic load;
  logic writes;

  assign load   = i_valid && !i_bubble;
  assign writes = (i_op == core_pkg::OP_ADD) || (i_op == core_pkg::OP_ADDI) ||
                  (i_op == core_pkg::OP_LW);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_op     <= core_pkg::OP_NOP;
      o_rdid   <= '0;
      o_rdwen  <= 1'b0;
      o_lden   <= 1'b0;
      o_rs1    <= '0;
      o_rs2    <= '0;
      o_imm    <= '0;
      o_ldstbp <= 1'b0;
    end else if (load) begin
      o_op     <= i_op;
      o_rdid   <= i_rdid;
      o_rdwen  <= writes && (i_rdid != '0); // the only place rd=0 is filtered
      o_lden   <= (i_op == core_pkg::OP_LW);
      o_rs1    <= i_rs1;
      o_rs2    <= i_rs2;
      o_imm    <= i_imm;
      o_ldstbp <= i_ldstbp;
    end else begin
      // bubble, operands are don't care
      o_op     <= core_pkg::OP_NOP;
      o_rdid   <= '0;
      o_rdwen  <= 1'b0;
      o_lden   <= 1'b0;
      o_ldstbp <= 1'b0;
    end
  end

  a_ldstbp_is_store : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_ldstbp |-> (o_op == core_pkg::OP_SW)
  );

endmodule

// File: hdl/exu.sv
module exu (
  input                      i_clk,
  input                      i_rst_n,
  // from id/ex
  input  core_pkg::op_e      i_op,
  input  core_pkg::reg_id_t  i_rdid,
  input                      i_rdwen,
  input                      i_lden,
  input  core_pkg::word_t    i_rs1,
  input  core_pkg::word_t    i_rs2,
  input  core_pkg::word_t    i_imm,
  input  core_pkg::word_t    i_stdata,    // store data after late bypass
  // ex result, also the ld/st address
  output core_pkg::word_t    o_exres,
  // ex/ls pipeline register
  output core_pkg::op_e      o_ls_op,
  output core_pkg::reg_id_t  o_ls_rdid,
  output logic               o_ls_rdwen,
  output logic               o_ls_lden,
  output core_pkg::word_t    o_ls_exres,
  output core_pkg::word_t    o_ls_stdata
);

  core_pkg::word_t opb;

  // second adder input
  always_comb begin
    case (i_op)
      core_pkg::OP_ADD:  opb = i_rs2;
      core_pkg::OP_ADDI,
      core_pkg::OP_LW,
      core_pkg::OP_SW:   opb = i_imm;
      default:           opb = '0;
    endcase
  end

  // a nop just passes rs1 through, nothing consumes it
  assign o_exres = i_rs1 + opb;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ls_op     <= core_pkg::OP_NOP;
      o_ls_rdid   <= '0;
      o_ls_rdwen  <= 1'b0;
      o_ls_lden   <= 1'b0;
      o_ls_exres  <= '0;
      o_ls_stdata <= '0;
    end else begin
      o_ls_op     <= i_op;
      o_ls_rdid   <= i_rdid;
      o_ls_rdwen  <= i_rdwen;
      o_ls_lden   <= i_lden;
      o_ls_exres  <= o_exres;
      o_ls_stdata <= i_stdata;
    end
  end

  // ex/ls flags must mirror the op they travel with
  a_lden_tracks_lw : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_ls_lden |-> (o_ls_op == core_pkg::OP_LW)
  );

endmodule

// File: hdl/lsu.sv
module lsu (
  input                      i_clk,
  input                      i_rst_n,
  // from ex/ls
  input  core_pkg::op_e      i_op,
  input  core_pkg::reg_id_t  i_rdid,
  input                      i_rdwen,
  input                      i_lden,
  input  core_pkg::word_t    i_exres,
  input  core_pkg::word_t    i_stdata,
  // load data, combinational
  output core_pkg::word_t    o_lsres,
  // ls/wb pipeline register
  output logic               o_wb_rdwen,
  output core_pkg::reg_id_t  o_wb_rdid,
  output core_pkg::word_t    o_wb_rd
);

  localparam int DMEM_WORDS = 1 << core_pkg::DMEM_AW;

  core_pkg::word_t              mem [DMEM_WORDS];
  logic [core_pkg::DMEM_AW-1:0] waddr;

  assign waddr   = i_exres[core_pkg::DMEM_AW+1:2]; // word index, upper bits ignored
  assign o_lsres = mem[waddr];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (i_op == core_pkg::OP_SW) begin
      mem[waddr] <= i_stdata;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_rdwen <= 1'b0;
      o_wb_rdid  <= '0;
      o_wb_rd    <= '0;
    end else begin
      o_wb_rdwen <= i_rdwen;
      o_wb_rdid  <= i_rdid;
      o_wb_rd    <= i_lden ? o_lsres : i_exres; // load data or alu result
    end
  end

  a_word_aligned : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    ((i_op == core_pkg::OP_LW) || (i_op == core_pkg::OP_SW)) |-> (i_exres[1:0] == 2'b00)
  );

endmodule

// File: hdl/backend_top.sv
module backend_top (
  input                      i_clk,
  input                      i_rst_n,
  // decoded instruction from the driver
  input                      i_id_valid,
  input  core_pkg::op_e      i_id_op,
  input  core_pkg::reg_id_t  i_id_rs1id,
  input  core_pkg::reg_id_t  i_id_rs2id,
  input  core_pkg::reg_id_t  i_id_rdid,
  input  core_pkg::word_t    i_id_imm,
  output logic               o_pc_wen,    // instruction accepted this edge
  // register write report
  output logic               o_wb_rdwen,
  output core_pkg::reg_id_t  o_wb_rdid,
  output core_pkg::word_t    o_wb_rd,
  output logic               o_a0zero
);

  // id side
  core_pkg::word_t   idu_rs1;
  core_pkg::word_t   idu_rs2;
  logic              idex_bubble;
  logic              idu_ldstbp;
  // ex stage
  core_pkg::op_e     exu_op;
  core_pkg::reg_id_t exu_rdid;
  logic              exu_rdwen;
  logic              exu_lden;
  core_pkg::word_t   exu_rs1;
  core_pkg::word_t   exu_rs2;
  core_pkg::word_t   exu_imm;
  logic              exu_ldstbp;
  core_pkg::word_t   exu_exres;
  core_pkg::word_t   exu_stdata;  // rs2 after late ld->st bypass
  // ls stage
  core_pkg::op_e     lsu_op;
  core_pkg::reg_id_t lsu_rdid;
  logic              lsu_rdwen;
  logic              lsu_lden;
  core_pkg::word_t   lsu_exres;
  core_pkg::word_t   lsu_stdata;
  core_pkg::word_t   lsu_lsres;

  bypass u_bypass (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_idu_rs1id (i_id_rs1id), .i_idu_rs2id (i_id_rs2id), .i_idu_op (i_id_op),
    .i_exu_lden (exu_lden), .i_exu_rdwen (exu_rdwen),
    .i_exu_rdid (exu_rdid), .i_exu_exres (exu_exres),
    .i_lsu_lden (lsu_lden), .i_lsu_rdwen (lsu_rdwen), .i_lsu_rdid (lsu_rdid),
    .i_lsu_exres (lsu_exres), .i_lsu_lsres (lsu_lsres),
    .i_wbu_rdwen (o_wb_rdwen), .i_wbu_rdid (o_wb_rdid), .i_wbu_rd (o_wb_rd),
    .i_exu_rs2 (exu_rs2), .i_exu_ldstbp (exu_ldstbp),
    .o_idu_rs1 (idu_rs1), .o_idu_rs2 (idu_rs2),
    .o_pc_wen (o_pc_wen), .o_idex_bubble (idex_bubble),
    .o_idu_ldstbp (idu_ldstbp), .o_exu_rs2 (exu_stdata),
    .o_a0zero (o_a0zero)
  );

  idex_reg u_idex_reg (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_valid (i_id_valid), .i_bubble (idex_bubble), .i_op (i_id_op),
    .i_rdid (i_id_rdid), .i_rs1 (idu_rs1), .i_rs2 (idu_rs2),
    .i_imm (i_id_imm), .i_ldstbp (idu_ldstbp),
    .o_op (exu_op), .o_rdid (exu_rdid), .o_rdwen (exu_rdwen), .o_lden (exu_lden),
    .o_rs1 (exu_rs1), .o_rs2 (exu_rs2), .o_imm (exu_imm), .o_ldstbp (exu_ldstbp)
  );

  exu u_exu (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_op (exu_op), .i_rdid (exu_rdid), .i_rdwen (exu_rdwen), .i_lden (exu_lden),
    .i_rs1 (exu_rs1), .i_rs2 (exu_rs2), .i_imm (exu_imm), .i_stdata (exu_stdata),
    .o_exres (exu_exres),
    .o_ls_op (lsu_op), .o_ls_rdid (lsu_rdid), .o_ls_rdwen (lsu_rdwen),
    .o_ls_lden (lsu_lden), .o_ls_exres (lsu_exres), .o_ls_stdata (lsu_stdata)
  );

  lsu u_lsu (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_op (lsu_op), .i_rdid (lsu_rdid), .i_rdwen (lsu_rdwen), .i_lden (lsu_lden),
    .i_exres (lsu_exres), .i_stdata (lsu_stdata),
    .o_lsres (lsu_lsres),
    .o_wb_rdwen (o_wb_rdwen), .o_wb_rdid (o_wb_rdid), .o_wb_rd (o_wb_rd)
  );

endmodule

// File: verification/tb_backend.sv
module tb_backend;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_TBL  = 21;
  localparam int N_RAND = 200;
  localparam int SEED   = 22194;

  typedef struct {
    core_pkg::op_e     op;
    core_pkg::reg_id_t rd;
    core_pkg::reg_id_t rs1;
    core_pkg::reg_id_t rs2;
    core_pkg::word_t   imm;
    core_pkg::word_t   exp;     // expected write value, unused when nothing is written
    int                stalls;
  } entry_t;

  logic              i_clk;
  logic              i_rst_n;
  logic              i_id_valid;
  core_pkg::op_e     i_id_op;
  core_pkg::reg_id_t i_id_rs1id;
  core_pkg::reg_id_t i_id_rs2id;
  core_pkg::reg_id_t i_id_rdid;
  core_pkg::word_t   i_id_imm;
  logic              o_pc_wen;
  logic              o_wb_rdwen;
  core_pkg::reg_id_t o_wb_rdid;
  core_pkg::word_t   o_wb_rd;
  logic              o_a0zero;

  entry_t            tbl [N_TBL];
  core_pkg::word_t   m_regs [32];                       // in-order reference state
  core_pkg::word_t   m_mem [1 << core_pkg::DMEM_AW];
  core_pkg::reg_id_t prev_ld_rd = '0;                   // rd of a load now in ex, 0 if none
  core_pkg::reg_id_t exp_rd_q [$];
  core_pkg::word_t   exp_val_q [$];
  core_pkg::word_t   mon_x10 = '0;
  int                n_checks = 0;
  int                n_errors = 0;
  int                n_pass = 0;
  int                n_fail = 0;

  backend_top dut (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_id_valid (i_id_valid), .i_id_op (i_id_op),
    .i_id_rs1id (i_id_rs1id), .i_id_rs2id (i_id_rs2id), .i_id_rdid (i_id_rdid),
    .i_id_imm (i_id_imm), .o_pc_wen (o_pc_wen), .o_wb_rdwen (o_wb_rdwen),
    .o_wb_rdid (o_wb_rdid), .o_wb_rd (o_wb_rd), .o_a0zero (o_a0zero)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // generous bound, an instruction needs at most two cycles plus drain
  initial begin
    repeat ((N_TBL + N_RAND) * 6) @(posedge i_clk);
    $display("timeout: run did not complete within %0d cycles", (N_TBL + N_RAND) * 6);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check_word(input string name, input core_pkg::word_t exp,
                            input core_pkg::word_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input core_pkg::reg_id_t exp,
                           input core_pkg::reg_id_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] t=%0t %s expected x%0d got x%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_stall(input string name, input int exp, input int act);
    n_checks++;
    if (exp != act) begin
      n_errors++;
      $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // compare every register write against the queue, a0zero tracks the expected x10
  always @(negedge i_clk) begin
    if (i_rst_n) begin
      check_flag("o_a0zero", (mon_x10 == '0), o_a0zero);
      if (o_wb_rdwen) begin
        if (exp_rd_q.size() == 0) begin
          n_errors++;
          $display("unexpected register write at t=%0t: x%0d <= %h", $time, o_wb_rdid, o_wb_rd);
        end else begin
          check_reg("o_wb_rdid", exp_rd_q[0], o_wb_rdid);
          check_word("o_wb_rd", exp_val_q[0], o_wb_rd);
          if (exp_rd_q[0] == 5'd10) mon_x10 = exp_val_q[0]; // visible after the next edge
          void'(exp_rd_q.pop_front());
          void'(exp_val_q.pop_front());
        end
      end
    end
  end

  task automatic set_entry(input int idx, input core_pkg::op_e op, input int rd, input int rs1,
                           input int rs2, input core_pkg::word_t imm, input core_pkg::word_t exp,
                           input int stalls);
    tbl[idx].op     = op;
    tbl[idx].rd     = core_pkg::reg_id_t'(rd);
    tbl[idx].rs1    = core_pkg::reg_id_t'(rs1);
    tbl[idx].rs2    = core_pkg::reg_id_t'(rs2);
    tbl[idx].imm    = imm;
    tbl[idx].exp    = exp;
    tbl[idx].stalls = stalls;
  endtask

  task automatic fill_table();
    set_entry(0,  core_pkg::OP_ADDI, 1,  0,  0,  32'd5,  32'd5,  0);
    set_entry(1,  core_pkg::OP_ADDI, 2,  1,  0,  32'd3,  32'd8,  0);  // x1 from ex
    set_entry(2,  core_pkg::OP_ADD,  3,  1,  2,  32'd0,  32'd13, 0);  // ls and ex
    set_entry(3,  core_pkg::OP_ADD,  4,  1,  3,  32'd0,  32'd18, 0);  // x1 from wb
    set_entry(4,  core_pkg::OP_ADD,  5,  1,  4,  32'd0,  32'd23, 0);  // x1 from regfile
    set_entry(5,  core_pkg::OP_ADDI, 10, 0,  0,  32'd7,  32'd7,  0);  // a0 nonzero
    set_entry(6,  core_pkg::OP_SW,   0,  0,  5,  32'd16, 32'd0,  0);
    set_entry(7,  core_pkg::OP_LW,   6,  0,  0,  32'd16, 32'd23, 0);
    set_entry(8,  core_pkg::OP_ADD,  7,  6,  1,  32'd0,  32'd28, 1);  // load-use
    set_entry(9,  core_pkg::OP_LW,   8,  0,  0,  32'd16, 32'd23, 0);
    set_entry(10, core_pkg::OP_SW,   0,  0,  8,  32'd32, 32'd0,  0);  // late store bypass
    set_entry(11, core_pkg::OP_LW,   9,  0,  0,  32'd32, 32'd23, 0);
    set_entry(12, core_pkg::OP_ADDI, 0,  5,  0,  32'd100, 32'd0, 0);  // dropped write to x0
    set_entry(13, core_pkg::OP_ADD,  11, 0,  5,  32'd0,  32'd23, 0);
    set_entry(14, core_pkg::OP_ADDI, 10, 10, 0,  32'hffff_fff9, 32'd0, 0);
    set_entry(15, core_pkg::OP_ADDI, 12, 0,  0,  32'd64, 32'd64, 0);
    set_entry(16, core_pkg::OP_SW,   0,  0,  12, 32'd8,  32'd0,  0);
    set_entry(17, core_pkg::OP_LW,   13, 0,  0,  32'd8,  32'd64, 0);
    set_entry(18, core_pkg::OP_SW,   0,  13, 13, 32'd4,  32'd0,  1);  // base is the load rd
    set_entry(19, core_pkg::OP_LW,   14, 0,  0,  32'd68, 32'd64, 0);
    set_entry(20, core_pkg::OP_ADDI, 15, 14, 0,  32'd1,  32'd65, 1);
  endtask

  // a store's data operand is not a hazard, the late bypass covers it
  function automatic logic load_use(input core_pkg::op_e op, input core_pkg::reg_id_t rs1,
                                    input core_pkg::reg_id_t rs2);
    logic hit;
    hit = 1'b0;
    if ((prev_ld_rd != '0) && (op != core_pkg::OP_NOP)) begin
      hit = (rs1 == prev_ld_rd) || ((op == core_pkg::OP_ADD) && (rs2 == prev_ld_rd));
    end
    return hit;
  endfunction

  task automatic model_exec(input core_pkg::op_e op, input core_pkg::reg_id_t rd,
                            input core_pkg::reg_id_t rs1, input core_pkg::reg_id_t rs2,
                            input core_pkg::word_t imm, output logic wr,
                            output core_pkg::word_t val);
    core_pkg::word_t addr;
    addr = m_regs[rs1] + imm;
    wr   = 1'b0;
    val  = '0;
    case (op)
      core_pkg::OP_ADD:  begin val = m_regs[rs1] + m_regs[rs2]; wr = 1'b1; end
      core_pkg::OP_ADDI: begin val = addr; wr = 1'b1; end
      core_pkg::OP_LW:   begin val = m_mem[addr[core_pkg::DMEM_AW+1:2]]; wr = 1'b1; end
      core_pkg::OP_SW:   m_mem[addr[core_pkg::DMEM_AW+1:2]] = m_regs[rs2];
      default:           ;
    endcase
    if (rd == '0) wr = 1'b0;
  endtask

  // present one instruction and hold it until accepted
  task automatic issue(input core_pkg::op_e op, input core_pkg::reg_id_t rd,
                       input core_pkg::reg_id_t rs1, input core_pkg::reg_id_t rs2,
                       input core_pkg::word_t imm, output int stalls);
    stalls     = 0;
    i_id_valid = 1'b1;
    i_id_op    = op;
    i_id_rdid  = rd;
    i_id_rs1id = rs1;
    i_id_rs2id = rs2;
    i_id_imm   = imm;
    @(negedge i_clk);
    while (!o_pc_wen) begin
      stalls++;
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
  endtask

  task automatic run_instr(input string name, input entry_t e, input logic use_tbl,
                           output int act_stalls, output int exp_stalls);
    logic            wr;
    core_pkg::word_t val;
    exp_stalls = load_use(e.op, e.rs1, e.rs2) ? 1 : 0;
    if (use_tbl) exp_stalls = e.stalls;
    model_exec(e.op, e.rd, e.rs1, e.rs2, e.imm, wr, val);
    if (use_tbl) val = e.exp;
    if (wr) begin
      m_regs[e.rd] = val;
      exp_rd_q.push_back(e.rd);
      exp_val_q.push_back(val);
    end
    prev_ld_rd = (e.op == core_pkg::OP_LW) ? e.rd : '0;
    issue(e.op, e.rd, e.rs1, e.rs2, e.imm, act_stalls);
    check_stall({name, " stalls"}, exp_stalls, act_stalls);
  endtask

  task automatic drain();
    int cnt;
    i_id_valid = 1'b0;
    i_id_op    = core_pkg::OP_NOP;
    prev_ld_rd = '0;
    cnt        = 0;
    while ((exp_rd_q.size() != 0) && (cnt < 20)) begin
      @(posedge i_clk);
      cnt++;
    end
    repeat (3) @(posedge i_clk); // a stray write would show up here
    #1;
    if (exp_rd_q.size() != 0) begin
      n_errors++;
      $display("missing register writes: %0d expected writes never appeared", exp_rd_q.size());
      exp_rd_q.delete();
      exp_val_q.delete();
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (n_errors == err_before) n_pass++;
    else n_fail++;
    $display("test %-10s %s, %0d errors", name, (n_errors == err_before) ? "passed" : "failed",
             n_errors - err_before);
  endtask

  initial begin
    int     err0;
    int     act;
    int     exp;
    int     rand_stalls;
    int     model_hazards;
    entry_t e;
    void'($urandom(SEED));
    i_rst_n    = 1'b0;
    i_id_valid = 1'b0;
    i_id_op    = core_pkg::OP_NOP;
    i_id_rs1id = '0;
    i_id_rs2id = '0;
    i_id_rdid  = '0;
    i_id_imm   = '0;
    foreach (m_regs[i]) m_regs[i] = '0;
    foreach (m_mem[i]) m_mem[i] = '0;
    fill_table();
    repeat (10) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    err0 = n_errors;
    @(negedge i_clk);
    check_flag("o_pc_wen", 1'b1, o_pc_wen);
    check_flag("o_wb_rdwen", 1'b0, o_wb_rdwen);
    check_flag("o_a0zero", 1'b1, o_a0zero);
    finish_test("reset", err0);
    @(posedge i_clk);
    #1;

    err0 = n_errors;
    for (int i = 0; i < N_TBL; i++) begin
      run_instr($sformatf("entry %0d", i), tbl[i], 1'b1, act, exp);
    end
    drain();
    finish_test("directed", err0);

    err0          = n_errors;
    rand_stalls   = 0;
    model_hazards = 0;
    for (int i = 0; i < N_RAND; i++) begin
      case ($urandom_range(0, 3))
        0:       e.op = core_pkg::OP_ADD;
        1:       e.op = core_pkg::OP_ADDI;
        2:       e.op = core_pkg::OP_LW;
        default: e.op = core_pkg::OP_SW;
      endcase
      e.rd  = core_pkg::reg_id_t'($urandom_range(0, 11)); // small set, frequent hazards
      e.rs1 = core_pkg::reg_id_t'($urandom_range(0, 11));
      e.rs2 = core_pkg::reg_id_t'($urandom_range(0, 11));
      e.imm = $urandom;
      if ((e.op == core_pkg::OP_LW) || (e.op == core_pkg::OP_SW)) begin
        e.imm = ($urandom & 32'h0000_00fc) - (m_regs[e.rs1] & 32'h3); // keep it word aligned
      end
      run_instr($sformatf("random %0d", i), e, 1'b0, act, exp);
      rand_stalls   += act;
      model_hazards += exp;
    end
    drain();
    check_stall("random stall total", model_hazards, rand_stalls);
    finish_test("random", err0);

    $display("tests %0d passed, %0d failed; %0d checks, %0d errors",
             n_pass, n_fail, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/core_pkg.sv
hdl/regfile.sv
hdl/bypass.sv
hdl/idex_reg.sv
hdl/exu.sv
hdl/lsu.sv
hdl/backend_top.sv
verification/tb_backend.sv

// File: Makefile
RTL = hdl/core_pkg.sv hdl/regfile.sv hdl/bypass.sv hdl/idex_reg.sv \
      hdl/exu.sv hdl/lsu.sv hdl/backend_top.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module tb_backend -f list.f

run: build
	@out="$$(./obj_dir/Vtb_backend)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --top-module backend_top $(RTL)

clean:
	rm -rf obj_dir
